// File: bench/board_io_checker.sv
/*
 * Reference model and scoreboard for the board I/O testbench
 * Samples the DUT ports at the falling edge, compares, then steps its own model
 */
`timescale 1ns/1ps

module board_io_checker
  import board_cfg_pkg::*;
  import board_io_pkg::*;
(
  input  logic        clk_i,

  // Test sequencing from the bench
  input  int          test_num_i,
  input  logic        test_end_i,         // Last cycle of the current test
  input  logic        all_done_i,

  // DUT inputs
  input  logic        reset_i,
  input  logic        gp_wr_i,
  input  led_t        gp_wdata_i,
  input  logic        rs485_tx_i,
  input  logic        rs485_tx_enable_i,
  input  logic        rs485_rx_enable_i,
  input  usr_sw_t     usr_sw_i,
  input  nav_sw_t     nav_sw_i,
  input  sel_sw_t     sel_sw_i,
  input  logic        microsd_det_i,
  input  logic        rs485_ro_i,

  // DUT outputs
  input  sw_state_t   gp_rdata_i,
  input  logic        rs485_rx_i,
  input  led_t        usr_led_i,
  input  logic        led_bootok_i,
  input  rs485_pins_t rs485_pins_i,

  output logic        summary_done_o,
  output int          error_count_o
);

  // Model state, valid for the cycle after the last falling edge
  rs485_state_e m_state    = IDLE;
  int unsigned  m_cyc      = 0;     // Cycles spent in m_state, current one included
  sw_state_t    m_sw       = '0;
  led_t         m_led      = '0;
  logic         m_bootok   = 1'b0;
  logic         primed     = 1'b0;  // Model in step with the DUT

  int   checks       = 0;
  int   errors       = 0;
  int   test_checks  = 0;
  int   test_errors  = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  logic summary_done = 1'b0;

  function automatic string test_label(input int num);
    string s;
    case (num)
      1:       s = "reset state";
      2:       s = "switch readback";
      3:       s = "LED register";
      4:       s = "transmit turnaround";
      5:       s = "receive gating";
      6:       s = "no receive during transmit";
      default: s = "unnamed";
    endcase
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks      = checks + 1;
    test_checks = test_checks + 1;
    if (act !== exp) begin  // X or Z counts as wrong
      errors      = errors + 1;
      test_errors = test_errors + 1;
      $display("ERROR %s expected 0x%0h actual 0x%0h (test %0d, %0t)",
               name, exp, act, test_num_i, $time);
    end
  endtask

  // Expected pins follow from the model state and the present host levels
  task automatic check_outputs();
    logic rx_open;
    logic exp_de;
    logic exp_di;
    rx_open = (m_state == IDLE) && rs485_rx_enable_i;  // Only path to the receiver
    exp_de  = (m_state == TX_TURN) || (m_state == TX) || (m_state == TX_HOLD);
    exp_di  = (m_state == TX) ? rs485_tx_i : 1'b1;     // Mark outside TX
    check_value("rs485_pins_o.de", 32'(exp_de), 32'(rs485_pins_i.de));
    check_value("rs485_pins_o.di", 32'(exp_di), 32'(rs485_pins_i.di));
    check_value("rs485_pins_o.ren", 32'(!rx_open), 32'(rs485_pins_i.ren));
    check_value("rs485_rx_o", 32'(rx_open ? rs485_ro_i : 1'b1), 32'(rs485_rx_i));
    check_value("gp_rdata_o", 32'(m_sw), 32'(gp_rdata_i));
    check_value("usr_led_o", 32'(m_led), 32'(usr_led_i));
    check_value("led_bootok_o", 32'(m_bootok), 32'(led_bootok_i));
  endtask

  task automatic enter_state(input rs485_state_e st);
    m_state = st;
    m_cyc   = 1;
  endtask

  // Guard states last exactly TURN_CYCLES cycles
  task automatic guard_step(input rs485_state_e next_st);
    if (m_cyc == TURN_CYCLES) enter_state(next_st);
    else m_cyc = m_cyc + 1;
  endtask

  // Inputs seen now are the ones the DUT samples at the next rising edge
  task automatic step_model();
    m_sw.microsd_det = microsd_det_i;  // Straight through
    m_sw.sel_sw      = ~sel_sw_i;
    m_sw.nav_sw      = ~nav_sw_i;
    m_sw.usr_sw      = ~usr_sw_i;
    if (reset_i) begin
      m_led    = '0;
      m_bootok = 1'b0;
      enter_state(IDLE);
    end else begin
      if (gp_wr_i) m_led = gp_wdata_i;
      m_bootok = 1'b1;
      case (m_state)
        IDLE:    if (rs485_tx_enable_i) enter_state(TX_TURN);
        TX_TURN: guard_step(TX);
        TX:      if (!rs485_tx_enable_i) enter_state(TX_HOLD);
        TX_HOLD: guard_step(RX_TURN);
        RX_TURN: guard_step(IDLE);
        default: enter_state(IDLE);
      endcase
    end
  endtask

  task automatic report_test();
    tests_run = tests_run + 1;
    if (test_errors == 0) begin
      $display("test %0d %s: PASS, %0d checks", test_num_i, test_label(test_num_i),
               test_checks);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: FAIL, %0d errors in %0d checks", test_num_i,
               test_label(test_num_i), test_errors, test_checks);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_summary();
    $display("%0d tests run, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, checks, errors);
    summary_done = 1'b1;
  endtask

  // Falling edge keeps sampling clear of the rising-edge stimulus
  always @(negedge clk_i) begin
    if (primed) check_outputs();
    if (test_end_i) report_test();
    if (reset_i === 1'b1) primed = 1'b1;  // DUT state known from here on
    if (primed) step_model();
    if (all_done_i && !summary_done) report_summary();
  end

  assign summary_done_o = summary_done;
  assign error_count_o  = errors;

endmodule : board_io_checker

// File: bench/tb_board_io.sv
/*
 * Testbench for the board I/O top level
 * Runs six tests with seeded random stimulus, board_io_checker does the comparing
 */
`timescale 1ns/1ps

module tb_board_io
  import board_cfg_pkg::*;
  import board_io_pkg::*;
();

  localparam int unsigned HALF_PERIOD_NS = 10;
  localparam int unsigned PERIOD_NS      = 2 * HALF_PERIOD_NS;
  localparam int          RAND_SEED      = 32'h62e8;

  // Test lengths in cycles, worst case, for the watchdog
  localparam int unsigned RESET_CYCLES  = 3;
  localparam int unsigned SETTLE_CYCLES = 4;
  localparam int unsigned SW_CYCLES     = 40;
  localparam int unsigned LED_CYCLES    = 40;
  localparam int unsigned TX_ROUNDS     = 4;
  localparam int unsigned TX_BITS_MAX   = 16;
  localparam int unsigned RX_CYCLES     = 60;
  localparam int unsigned LISTEN_BITS   = 10;
  localparam int unsigned DRAIN_CYCLES  = 3 * TURN_CYCLES + 4;  // Hold, RX turn and slack
  localparam int unsigned ROUND_MAX     = TURN_CYCLES + TX_BITS_MAX + DRAIN_CYCLES + 2;
  localparam int unsigned LISTEN_MAX    = TURN_CYCLES + LISTEN_BITS + DRAIN_CYCLES + 8;
  localparam int unsigned TOTAL_CYCLES  = RESET_CYCLES + SETTLE_CYCLES + SW_CYCLES
                                        + LED_CYCLES + TX_ROUNDS * ROUND_MAX + RX_CYCLES
                                        + LISTEN_MAX + 6 * 2 + 4;
  localparam int unsigned MARGIN_CYCLES = 100;
  localparam int unsigned TIMEOUT_NS    = (TOTAL_CYCLES + MARGIN_CYCLES) * PERIOD_NS;

  logic        clk_sys = 1'b0;
  logic        reset;
  logic        gp_wr;
  led_t        gp_wdata;
  sw_state_t   gp_rdata;
  logic        rs485_tx;
  logic        rs485_tx_enable;
  logic        rs485_rx_enable;
  logic        rs485_rx;
  usr_sw_t     usr_sw;
  nav_sw_t     nav_sw;
  sel_sw_t     sel_sw;
  logic        microsd_det;
  led_t        usr_led;
  logic        led_bootok;
  rs485_pins_t rs485_pins;
  logic        rs485_ro;

  int   test_num = 1;
  logic test_end = 1'b0;
  logic all_done = 1'b0;
  logic summary_done;
  int   error_count;

  always #(HALF_PERIOD_NS) clk_sys = ~clk_sys;

  board_io_top UUT (
    .clk_sys_i        (clk_sys),
    .reset_i          (reset),
    .gp_wr_i          (gp_wr),
    .gp_wdata_i       (gp_wdata),
    .gp_rdata_o       (gp_rdata),
    .rs485_tx_i       (rs485_tx),
    .rs485_tx_enable_i(rs485_tx_enable),
    .rs485_rx_enable_i(rs485_rx_enable),
    .rs485_rx_o       (rs485_rx),
    .usr_sw_i         (usr_sw),
    .nav_sw_i         (nav_sw),
    .sel_sw_i         (sel_sw),
    .microsd_det_i    (microsd_det),
    .usr_led_o        (usr_led),
    .led_bootok_o     (led_bootok),
    .rs485_pins_o     (rs485_pins),
    .rs485_ro_i       (rs485_ro)
  );

  board_io_checker u_checker (
    .clk_i            (clk_sys),
    .test_num_i       (test_num),
    .test_end_i       (test_end),
    .all_done_i       (all_done),
    .reset_i          (reset),
    .gp_wr_i          (gp_wr),
    .gp_wdata_i       (gp_wdata),
    .rs485_tx_i       (rs485_tx),
    .rs485_tx_enable_i(rs485_tx_enable),
    .rs485_rx_enable_i(rs485_rx_enable),
    .usr_sw_i         (usr_sw),
    .nav_sw_i         (nav_sw),
    .sel_sw_i         (sel_sw),
    .microsd_det_i    (microsd_det),
    .rs485_ro_i       (rs485_ro),
    .gp_rdata_i       (gp_rdata),
    .rs485_rx_i       (rs485_rx),
    .usr_led_i        (usr_led),
    .led_bootok_i     (led_bootok),
    .rs485_pins_i     (rs485_pins),
    .summary_done_o   (summary_done),
    .error_count_o    (error_count)
  );

  // Time zero, before the first edge
  task automatic init_inputs();
    reset           <= 1'b1;
    gp_wr           <= 1'b0;
    gp_wdata        <= '0;
    rs485_tx        <= 1'b1;
    rs485_tx_enable <= 1'b0;
    rs485_rx_enable <= 1'b0;
    usr_sw          <= '1;  // All switches released
    nav_sw          <= '1;
    sel_sw          <= '1;
    microsd_det     <= 1'b0;
    rs485_ro        <= 1'b1;
  endtask

  // One flagged cycle so the checker reports the test
  task automatic close_test();
    @(posedge clk_sys);
    test_end <= 1'b1;
    @(posedge clk_sys);
    test_end <= 1'b0;
    test_num <= test_num + 1;
  endtask

  task automatic drive_switches();
    repeat (SW_CYCLES) begin
      @(posedge clk_sys);
      usr_sw      <= usr_sw_t'($urandom);
      nav_sw      <= nav_sw_t'($urandom);
      sel_sw      <= sel_sw_t'($urandom);
      microsd_det <= 1'($urandom);
    end
  endtask

  task automatic write_leds();
    repeat (LED_CYCLES) begin
      @(posedge clk_sys);
      gp_wr    <= 1'($urandom);  // About half the cycles strobe
      gp_wdata <= led_t'($urandom);
    end
    @(posedge clk_sys);
    gp_wr <= 1'b0;
  endtask

  // One transmit burst, optionally with enable glitches inside the guards
  task automatic send_frame(input logic glitch);
    int unsigned nbits;
    int unsigned i;
    nbits = $urandom_range(TX_BITS_MAX, 4);
    @(posedge clk_sys);
    rs485_tx_enable <= 1'b1;
    rs485_tx        <= 1'($urandom);
    for (i = 0; i < TURN_CYCLES; i++) begin  // TX_TURN, bits must stay off the line
      @(posedge clk_sys);
      rs485_tx <= 1'($urandom);
      if (glitch) rs485_tx_enable <= (i != 1);
    end
    rs485_tx_enable <= 1'b1;
    repeat (nbits) begin
      @(posedge clk_sys);
      rs485_tx <= 1'($urandom);
    end
    @(posedge clk_sys);
    rs485_tx_enable <= 1'b0;
    for (i = 0; i < DRAIN_CYCLES; i++) begin  // TX_HOLD, RX_TURN, back to IDLE
      @(posedge clk_sys);
      rs485_tx <= 1'($urandom);
      if (glitch && i == 2) rs485_tx_enable <= 1'b1;  // Ignored in TX_HOLD
      if (glitch && i == 3) rs485_tx_enable <= 1'b0;
      if (glitch && i == 6) rs485_tx_enable <= 1'b1;  // Ignored in RX_TURN
      if (glitch && i == 7) rs485_tx_enable <= 1'b0;
    end
  endtask

  task automatic exercise_turnaround();
    int unsigned r;
    for (r = 0; r < TX_ROUNDS; r++) begin
      send_frame(r[0]);  // Every second round glitches
    end
  endtask

  task automatic gate_receiver();
    repeat (RX_CYCLES) begin
      @(posedge clk_sys);
      rs485_rx_enable <= 1'($urandom);
      rs485_ro        <= 1'($urandom);
    end
  endtask

  // Receiver asked for throughout a full transmit cycle
  task automatic listen_through_transmit();
    logic open;
    open = 1'b0;
    @(posedge clk_sys);
    rs485_rx_enable <= 1'b1;
    rs485_tx_enable <= 1'b1;
    repeat (TURN_CYCLES + LISTEN_BITS) begin
      @(posedge clk_sys);
      rs485_tx <= 1'($urandom);
      rs485_ro <= 1'($urandom);
    end
    rs485_tx_enable <= 1'b0;
    while (!open) begin  // Until the DUT opens the receiver again
      @(posedge clk_sys);
      rs485_ro <= 1'($urandom);
      @(negedge clk_sys);
      open = (rs485_pins.ren == 1'b0);
    end
    repeat (4) begin
      @(posedge clk_sys);
      rs485_ro <= 1'($urandom);
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    init_inputs();
    repeat (RESET_CYCLES) @(posedge clk_sys);
    reset <= 1'b0;
    repeat (SETTLE_CYCLES) @(posedge clk_sys);
    close_test();
    drive_switches();
    close_test();
    write_leds();
    close_test();
    exercise_turnaround();
    close_test();
    gate_receiver();
    close_test();
    listen_through_transmit();
    close_test();
    all_done <= 1'b1;
    while (!summary_done) @(posedge clk_sys);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns before all tests finished", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

endmodule : tb_board_io

// File: hw/board_cfg_pkg.sv
/*
 * Board timing constants shared by the RS-485 guard timer and the bench
 * Guard length is derived from the system clock and transceiver switch time
 */
package board_cfg_pkg;

  // System clock in Hz
  localparam int unsigned SYS_CLK_FREQ = 40_000_000;

  // 90 ns transceiver switch time plus 10 ns margin
  localparam int unsigned SWITCH_DELAY_NS = 90 + 10;

  localparam int unsigned CLK_PERIOD_NS = 1_000_000_000 / SYS_CLK_FREQ;  // 25 ns

  // Division rounds down, so one cycle added to cover the remainder
  localparam int unsigned TURN_CYCLES = (SWITCH_DELAY_NS / CLK_PERIOD_NS) + 1;

  // Counter must hold TURN_CYCLES itself
  localparam int unsigned TURN_CNT_W = $clog2(TURN_CYCLES + 1);

  typedef logic [TURN_CNT_W-1:0] turn_cnt_t;

  // Value loaded at guard entry
  // Entry cycle is already the first guard cycle, so zero marks the last one
  localparam turn_cnt_t TURN_LOAD = turn_cnt_t'(TURN_CYCLES - 1);

endpackage : board_cfg_pkg

// File: hw/board_gpio.sv
/*
 * Board switches and LEDs as seen by the host
 * Switches are sampled and inverted, LEDs are a host-written register
 */
`timescale 1ns/1ps

module board_gpio
  import board_io_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,

  // Switch pins, active low (pulled up, switch grounds)
  input  usr_sw_t   usr_sw_i,
  input  nav_sw_t   nav_sw_i,
  input  sel_sw_t   sel_sw_i,
  input  logic      microsd_det_i,  // Not inverted

  // Host port
  input  logic      gp_wr_i,        // One-cycle write strobe
  input  led_t      gp_wdata_i,
  output sw_state_t gp_rdata_o,

  // LED pins
  output led_t      usr_led_o,
  output logic      led_bootok_o
);

  sw_state_t sw_d;     // Inverted pin view
  sw_state_t sw_q;
  led_t      led_q;
  logic      bootok_q;

  // Flip to 1 = on before sampling
  always_comb begin
    sw_d.microsd_det = microsd_det_i;
    sw_d.sel_sw      = ~sel_sw_i;
    sw_d.nav_sw      = ~nav_sw_i;
    sw_d.usr_sw      = ~usr_sw_i;
  end

  // Switch sample register, free running
  always_ff @(posedge clk_sys_i) begin
    sw_q <= sw_d;
  end

  // LED register, holds between writes
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      led_q <= '0;
    end else if (gp_wr_i) begin
      led_q <= gp_wdata_i;
    end
  end

  // Boot-ok goes high on the first edge out of reset
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      bootok_q <= 1'b0;
    end else begin
      bootok_q <= 1'b1;
    end
  end

  assign gp_rdata_o   = sw_q;
  assign usr_led_o    = led_q;
  assign led_bootok_o = bootok_q;

endmodule : board_gpio

// File: hw/board_io_pkg.sv
/*
 * Pin and host-side types for the board I/O block
 * Switch, LED and RS-485 bundles plus the transceiver state encoding
 */
package board_io_pkg;

  // Raw switch and LED widths
  typedef logic [7:0] usr_sw_t;  // User DIP switches
  typedef logic [4:0] nav_sw_t;  // Joystick
  typedef logic [2:0] sel_sw_t;  // Software select switches
  typedef logic [7:0] led_t;     // User LEDs

  // Host view of the switches, 1 = on
  // Field order matches the GPIO input word, card detect on top
  typedef struct packed {
    logic    microsd_det;  // Card insertion detect, passed as is
    sel_sw_t sel_sw;
    nav_sw_t nav_sw;
    usr_sw_t usr_sw;
  } sw_state_t;

  // Transceiver control pins
  typedef struct packed {
    logic di;   // Driver data
    logic de;   // Driver enable, active high
    logic ren;  // Receiver enable, active low
  } rs485_pins_t;

  // Transceiver direction states
  // Guard states hold the line while the transceiver turns around
  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // Receiver may be on
    TX_TURN = 3'd1,  // Driver on, data held high
    TX      = 3'd2,  // Driver on, data live
    TX_HOLD = 3'd3,  // Driver kept on after last bit
    RX_TURN = 3'd4   // Driver off, receiver still blocked
  } rs485_state_e;

  // Idle line level on the driver data pin
  localparam logic RS485_MARK = 1'b1;

endpackage : board_io_pkg

// File: hw/board_io_top.sv
/*
 * Board I/O top level
 * Connects the switch/LED block and the RS-485 direction control
 * between the host port and the board pins
 */
`timescale 1ns/1ps

module board_io_top
  import board_io_pkg::*;
(
  input  logic        clk_sys_i,
  input  logic        reset_i,

  // Host GPIO
  input  logic        gp_wr_i,
  input  led_t        gp_wdata_i,
  output sw_state_t   gp_rdata_o,

  // Host RS-485
  input  logic        rs485_tx_i,
  input  logic        rs485_tx_enable_i,
  input  logic        rs485_rx_enable_i,
  output logic        rs485_rx_o,

  // Switch pins, active low except card detect
  input  usr_sw_t     usr_sw_i,
  input  nav_sw_t     nav_sw_i,
  input  sel_sw_t     sel_sw_i,
  input  logic        microsd_det_i,

  // LED pins
  output led_t        usr_led_o,
  output logic        led_bootok_o,

  // Transceiver pins
  output rs485_pins_t rs485_pins_o,
  input  logic        rs485_ro_i
);

  logic timer_start;  // FSM to timer
  logic timer_done;   // Timer to FSM

  // Switches and LEDs
  board_gpio u_board_gpio (
    .clk_sys_i    (clk_sys_i),
    .reset_i      (reset_i),
    .usr_sw_i     (usr_sw_i),
    .nav_sw_i     (nav_sw_i),
    .sel_sw_i     (sel_sw_i),
    .microsd_det_i(microsd_det_i),
    .gp_wr_i      (gp_wr_i),
    .gp_wdata_i   (gp_wdata_i),
    .gp_rdata_o   (gp_rdata_o),
    .usr_led_o    (usr_led_o),
    .led_bootok_o (led_bootok_o)
  );

  // Transceiver direction control
  rs485_fsm u_rs485_fsm (
    .clk_sys_i    (clk_sys_i),
    .reset_i      (reset_i),
    .tx_i         (rs485_tx_i),
    .tx_enable_i  (rs485_tx_enable_i),
    .rx_enable_i  (rs485_rx_enable_i),
    .rx_o         (rs485_rx_o),
    .ro_i         (rs485_ro_i),
    .pins_o       (rs485_pins_o),
    .timer_done_i (timer_done),
    .timer_start_o(timer_start)
  );

  // One timer serves all three guard states
  rs485_timer u_rs485_timer (
    .clk_sys_i(clk_sys_i),
    .reset_i  (reset_i),
    .start_i  (timer_start),
    .done_o   (timer_done)
  );

endmodule : board_io_top

// File: hw/rs485_fsm.sv
/*
 * RS-485 half-duplex direction control
 * Steps through guard periods around every turnaround and decodes
 * driver enable, receiver enable and the gated data bits from the state
 */
`timescale 1ns/1ps

module rs485_fsm
  import board_io_pkg::*;
(
  input  logic        clk_sys_i,
  input  logic        reset_i,

  // Host side
  input  logic        tx_i,         // Serial bit to send
  input  logic        tx_enable_i,  // Level, host wants the line
  input  logic        rx_enable_i,  // Level, host wants to listen
  output logic        rx_o,         // Received bit, idles high

  // Transceiver side
  input  logic        ro_i,         // Receiver output from the part
  output rs485_pins_t pins_o,

  // Guard timer link
  input  logic        timer_done_i,
  output logic        timer_start_o
);

  rs485_state_e state_q;
  rs485_state_e state_d;

  logic rx_active;  // Receiver path open

  // Guard states are the ones timed by the shared counter
  function automatic logic is_guard(input rs485_state_e st);
    logic res;
    res = (st == TX_TURN) || (st == TX_HOLD) || (st == RX_TURN);
    return res;
  endfunction

  // State register
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  // Enable changes in a guard state wait until the guard is over
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (tx_enable_i) state_d = TX_TURN;  // Turn driver on first
      end
      TX_TURN: begin
        if (timer_done_i) state_d = TX;
      end
      TX: begin
        if (!tx_enable_i) state_d = TX_HOLD;  // Keep driving a little longer
      end
      TX_HOLD: begin
        if (timer_done_i) state_d = RX_TURN;
      end
      RX_TURN: begin
        if (timer_done_i) state_d = IDLE;  // Transceiver settled
      end
      default: state_d = IDLE;
    endcase
  end

  // Start pulse in the cycle that commits a guard entry
  // Loads the timer on the same edge that the state changes
  assign timer_start_o = (state_d != state_q) && is_guard(state_d);

  // Receiver only in IDLE and only when asked for
  assign rx_active = (state_q == IDLE) && rx_enable_i;

  // Pin decode, purely from the registered state
  always_comb begin
    pins_o.de  = (state_q == TX_TURN) || (state_q == TX) || (state_q == TX_HOLD);
    pins_o.ren = ~rx_active;                                // Active low
    pins_o.di  = (state_q == TX) ? tx_i : RS485_MARK;       // Line idles at mark
  end

  // Host sees a quiet line unless the receiver is open
  assign rx_o = rx_active ? ro_i : 1'b1;

endmodule : rs485_fsm

// File: hw/rs485_timer.sv
/*
 * Guard period timer for the RS-485 direction FSM
 * Loaded by a one-cycle start pulse, done stays high until the next start
 */
`timescale 1ns/1ps

module rs485_timer
  import board_cfg_pkg::*;
(
  input  logic clk_sys_i,
  input  logic reset_i,
  input  logic start_i,  // Pulse on entry to a guard state
  output logic done_o    // High on the last guard cycle and after
);

  turn_cnt_t cnt_q;  // Guard cycles left after the current one

  // Down counter
  // Start wins over the decrement, so back-to-back guards reload cleanly
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      cnt_q <= '0;  // Expired out of reset
    end else if (start_i) begin
      cnt_q <= TURN_LOAD;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - turn_cnt_t'(1);  // Stops at zero
    end
  end

  // Zero means the guard is used up
  // FSM sees this in the final guard cycle and leaves at the next edge
  assign done_o = (cnt_q == '0);

endmodule : rs485_timer

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the board I/O testbench with Verilator and run it into sim.log
# Exit status is nonzero when the build fails or the log reports a failure

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 -f verilog.f --top-module tb_board_io -o sim_board_io \
  && ./obj_dir/sim_board_io > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

# Any failure line in the log fails the run
grep -q "sim failed" sim.log && exit 1 || exit 0

// File: verilog.f
hw/board_cfg_pkg.sv
hw/board_io_pkg.sv
hw/rs485_timer.sv
hw/rs485_fsm.sv
hw/board_gpio.sv
hw/board_io_top.sv
bench/board_io_checker.sv
bench/tb_board_io.sv
